//--- Makefile
VERILATOR ?= verilator
FILELIST  ?= icache_top.f
TB_TOP    ?= tb_icache_top
RTL_TOP   ?= icache_top
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert --timescale 1ns/1ps
PASS_MSG  ?= Done: no errors

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TB_TOP) | tee $(LOG)
	grep -qx "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- icache_top.f
+incdir+src
src/icache_pkg.sv
src/refill_if.sv
src/icache_array.sv
src/axi_refill_master.sv
src/fetch_ctrl.sv
src/icache_top.sv
verification/axi_mem_model.sv
verification/tb_icache_top.sv

//--- src/axi_refill_master.sv
module axi_refill_master (
    input  logic                   clock,
    input  logic                   reset,
    refill_if.master               refill,
    output logic                   ar_valid_o,
    input  logic                   ar_ready_i,
    output icache_pkg::addr_t      ar_addr_o,
    input  logic                   r_valid_i,
    output logic                   r_ready_o,
    input  icache_pkg::word_t      r_data_i,
    input  icache_pkg::axi_resp_e  r_resp_i,
    input  logic                   r_last_i
);
    import icache_pkg::*;

    refill_state_e state_q, state_d;
    addr_t         addr_q;       // held for the whole ar phase
    beat_t         beat_cnt_q;   // index of the next r beat
    logic          cmd_hs;
    logic          r_hs;

    assign cmd_hs = refill.cmd_valid && refill.cmd_ready;
    assign r_hs   = r_valid_i && r_ready_o;

    always_comb begin
        state_d = state_q;
        case (state_q)
            R_IDLE: begin
                if (cmd_hs) state_d = R_ADDR;
            end
            R_ADDR: begin
                if (ar_ready_i) state_d = R_DATA;    // ar accepted
            end
            R_DATA: begin
                if (r_hs && r_last_i) state_d = R_IDLE;
            end
            default: begin
                state_d = R_IDLE;
            end
        endcase
    end

    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            state_q <= R_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    always_ff @(posedge clock) begin
        if (cmd_hs) begin
            addr_q <= refill.cmd_addr;
        end
    end

    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            beat_cnt_q <= '0;
        end else if (cmd_hs) begin
            beat_cnt_q <= '0;
        end else if (r_hs) begin
            beat_cnt_q <= beat_cnt_q + 1'b1;   // wraps to 0 after the last beat
        end
    end

    // one line at a time
    assign refill.cmd_ready = (state_q == R_IDLE);

    assign ar_valid_o = (state_q == R_ADDR);
    assign ar_addr_o  = addr_q;
    assign r_ready_o  = (state_q == R_DATA);

    // beats pass straight through, tagged with their position
    assign refill.beat_valid = r_hs;
    assign refill.beat_idx   = beat_cnt_q;
    assign refill.beat_data  = r_data_i;
    assign refill.beat_last  = r_hs && r_last_i;
    assign refill.beat_resp  = r_resp_i;

    // ar must not change while the slave stalls
    property p_ar_stable;
        @(posedge clock) disable iff (!reset)
        ar_valid_o && !ar_ready_i |=> ar_valid_o && $stable(ar_addr_o);
    endproperty
    a_ar_stable: assert property (p_ar_stable)
        else $error("ar address changed while waiting for ar_ready");

    // slave must end the burst on the fourth beat, no earlier, no later
    property p_rlast_on_last_beat;
        @(posedge clock) disable iff (!reset)
        r_hs |-> (r_last_i == (beat_cnt_q == LAST_BEAT));
    endproperty
    a_rlast_on_last_beat: assert property (p_rlast_on_last_beat)
        else $error("rlast does not match beat count %0d", beat_cnt_q);

endmodule

//--- src/fetch_ctrl.sv
module fetch_ctrl (
    input  logic                   clock,
    input  logic                   reset,
    input  logic                   fetch_valid_i,
    input  icache_pkg::addr_t      fetch_addr_i,
    output logic                   fetch_ready_o,
    output logic                   resp_valid_o,
    output icache_pkg::word_t      resp_data_o,
    output icache_pkg::axi_resp_e  resp_err_o,
    input  logic                   resp_ready_i,
    output logic                   lookup_en_o,
    output icache_pkg::addr_t      lookup_addr_o,
    input  logic                   hit_i,
    input  icache_pkg::word_t      data_i,
    refill_if.ctrl                 refill
);
    import icache_pkg::*;

    fetch_state_e state_q, state_d;
    addr_t        addr_q;         // request in flight
    logic         cmd_valid_q;
    word_t        resp_data_q;    // compare register, held through RESP
    axi_resp_e    resp_err_q;     // worst beat response of the refill
    logic         req_hs;
    logic         cmd_hs;
    logic         beat_match;

    assign req_hs     = fetch_valid_i && fetch_ready_o;
    assign cmd_hs     = refill.cmd_valid && refill.cmd_ready;
    assign beat_match = refill.beat_valid && (refill.beat_idx == addr_beat(addr_q));

    // lookup goes out on the handshake itself, hit_i is ready in LOOKUP
    assign lookup_en_o   = req_hs;
    assign lookup_addr_o = fetch_addr_i;

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: begin
                if (req_hs) state_d = LOOKUP;
            end
            LOOKUP: begin
                state_d = hit_i ? RESP : REFILL;
            end
            REFILL: begin
                if (refill.beat_valid && refill.beat_last) state_d = RESP;
            end
            RESP: begin
                if (resp_ready_i) state_d = IDLE;
            end
            default: begin
                state_d = IDLE;
            end
        endcase
    end

    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    always_ff @(posedge clock) begin
        if (req_hs) begin
            addr_q <= fetch_addr_i;
        end
    end

    // refill command raised on a miss, dropped once the master takes it
    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            cmd_valid_q <= 1'b0;
        end else if (state_q == LOOKUP && !hit_i) begin
            cmd_valid_q <= 1'b1;
        end else if (cmd_hs) begin
            cmd_valid_q <= 1'b0;
        end
    end

    always_ff @(posedge clock) begin
        if (state_q == LOOKUP && hit_i) begin
            resp_data_q <= data_i;             // hit, array word
        end else if (state_q == REFILL && beat_match) begin
            resp_data_q <= refill.beat_data;   // miss, the requested beat
        end
    end

    always_ff @(posedge clock) begin
        if (state_q == LOOKUP) begin
            resp_err_q <= OKAY;
        end else if (state_q == REFILL && refill.beat_valid
                     && refill.beat_resp > resp_err_q) begin
            resp_err_q <= refill.beat_resp;
        end
    end

    assign fetch_ready_o = (state_q == IDLE);   // one request at a time
    assign resp_valid_o  = (state_q == RESP);
    assign resp_data_o   = resp_data_q;
    assign resp_err_o    = resp_err_q;

    assign refill.cmd_valid = cmd_valid_q;
    assign refill.cmd_addr  = line_base(addr_q);

    // response held until the fetch unit takes it
    property p_resp_stable;
        @(posedge clock) disable iff (!reset)
        resp_valid_o && !resp_ready_i |=>
            resp_valid_o && $stable(resp_data_o) && $stable(resp_err_o);
    endproperty
    a_resp_stable: assert property (p_resp_stable)
        else $error("response changed under back-pressure");

endmodule

//--- src/icache_array.sv
`include "icache_params.svh"

module icache_array (
    input  logic               clock,
    input  logic               reset,
    input  logic               lookup_en_i,
    input  icache_pkg::addr_t  lookup_addr_i,
    output logic               hit_o,
    output icache_pkg::word_t  data_o,
    refill_if.array            refill
);
    import icache_pkg::*;

    tag_t  tag_mem  [`ICACHE_LINES];
    word_t data_mem [`ICACHE_LINES][`ICACHE_LINE_WORDS];
    logic [`ICACHE_LINES-1:0] valid_q;

    index_t fill_index_q;   // line under refill
    tag_t   fill_tag_q;
    logic   fill_ok_q;      // every beat so far came back okay

    index_t lk_index;
    logic   cmd_hs;

    assign lk_index = addr_index(lookup_addr_i);
    assign cmd_hs   = refill.cmd_valid && refill.cmd_ready;

    // registered lookup, result one cycle after lookup_en_i
    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            hit_o <= 1'b0;
        end else if (lookup_en_i) begin
            hit_o <= valid_q[lk_index] && (tag_mem[lk_index] == addr_tag(lookup_addr_i));
        end
    end

    always_ff @(posedge clock) begin
        if (lookup_en_i) begin
            data_o <= data_mem[lk_index][addr_beat(lookup_addr_i)];
        end
    end

    // target line taken from the command
    always_ff @(posedge clock) begin
        if (cmd_hs) begin
            fill_index_q <= addr_index(refill.cmd_addr);
            fill_tag_q   <= addr_tag(refill.cmd_addr);
        end
    end

    // beat writes, tag goes in with the last one
    always_ff @(posedge clock) begin
        if (refill.beat_valid) begin
            data_mem[fill_index_q][refill.beat_idx] <= refill.beat_data;
            if (refill.beat_last) begin
                tag_mem[fill_index_q] <= fill_tag_q;
            end
        end
    end

    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            fill_ok_q <= 1'b0;
        end else if (cmd_hs) begin
            fill_ok_q <= 1'b1;   // new burst, clean slate
        end else if (refill.beat_valid && refill.beat_resp != OKAY) begin
            fill_ok_q <= 1'b0;
        end
    end

    // line only becomes valid if the whole burst was okay
    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            valid_q <= '0;
        end else if (refill.beat_valid && refill.beat_last) begin
            valid_q[fill_index_q] <= fill_ok_q && (refill.beat_resp == OKAY);
        end
    end

    // controller must only refill a line that really missed
    property p_refill_only_on_miss;
        @(posedge clock) disable iff (!reset)
        refill.beat_valid |->
            !(valid_q[fill_index_q] && (tag_mem[fill_index_q] == fill_tag_q));
    endproperty
    a_refill_only_on_miss: assert property (p_refill_only_on_miss)
        else $error("refill beat for a line that already hits");

endmodule

//--- src/icache_params.svh
`ifndef ICACHE_PARAMS_SVH
`define ICACHE_PARAMS_SVH

// cache geometry, shared by the package and the storage arrays

// byte address width of the fetch and axi side
`define ICACHE_ADDR_W 32

// one instruction word, also the axi data width
`define ICACHE_WORD_W 64

// direct mapped, one line per index
`define ICACHE_LINES 16

// words per line, one axi beat each
`define ICACHE_LINE_WORDS 4

`endif

//--- src/icache_pkg.sv
package icache_pkg;

    `include "icache_params.svh"

    // address split: | tag | index | beat | byte |
    localparam int BYTE_OFF_W = $clog2(`ICACHE_WORD_W / 8);   // 3
    localparam int BEAT_W     = $clog2(`ICACHE_LINE_WORDS);   // 2
    localparam int INDEX_W    = $clog2(`ICACHE_LINES);        // 4
    localparam int OFFSET_W   = BYTE_OFF_W + BEAT_W;          // line offset, 5
    localparam int TAG_W      = `ICACHE_ADDR_W - OFFSET_W - INDEX_W;

    typedef logic [`ICACHE_ADDR_W-1:0] addr_t;
    typedef logic [`ICACHE_WORD_W-1:0] word_t;
    typedef logic [INDEX_W-1:0]        index_t;
    typedef logic [TAG_W-1:0]          tag_t;
    typedef logic [BEAT_W-1:0]         beat_t;

    localparam beat_t LAST_BEAT = beat_t'(`ICACHE_LINE_WORDS - 1);   // also arlen

    // fixed ar fields
    localparam logic [1:0] AXI_BURST_INCR      = 2'b01;
    localparam logic [2:0] AXI_PROT_INSTR      = 3'b100;   // unprivileged, secure, instr
    localparam logic [3:0] AXI_CACHE_NORMAL_NC = 4'b0010;  // normal non-cacheable

    // numeric order doubles as severity, okay lowest
    typedef enum logic [1:0] {
        OKAY   = 2'b00,
        EXOKAY = 2'b01,
        SLVERR = 2'b10,
        DECERR = 2'b11
    } axi_resp_e;

    typedef enum logic [1:0] {
        IDLE,
        LOOKUP,
        REFILL,
        RESP
    } fetch_state_e;

    typedef enum logic [1:0] {
        R_IDLE,
        R_ADDR,
        R_DATA
    } refill_state_e;

    function automatic index_t addr_index(addr_t addr);
        return addr[OFFSET_W +: INDEX_W];
    endfunction

    function automatic tag_t addr_tag(addr_t addr);
        return addr[`ICACHE_ADDR_W-1 -: TAG_W];
    endfunction

    function automatic beat_t addr_beat(addr_t addr);
        return addr[BYTE_OFF_W +: BEAT_W];
    endfunction

    // first byte of the line holding addr
    function automatic addr_t line_base(addr_t addr);
        return {addr[`ICACHE_ADDR_W-1:OFFSET_W], {OFFSET_W{1'b0}}};
    endfunction

endpackage

//--- src/icache_top.sv
module icache_top (
    input  logic                   clock,
    input  logic                   reset,
    // fetch side
    input  logic                   fetch_valid_i,
    input  icache_pkg::addr_t      fetch_addr_i,
    output logic                   fetch_ready_o,
    output logic                   resp_valid_o,
    output icache_pkg::word_t      resp_data_o,
    output icache_pkg::axi_resp_e  resp_err_o,
    input  logic                   resp_ready_i,
    // axi ar channel
    output logic                   ar_valid_o,
    input  logic                   ar_ready_i,
    output icache_pkg::addr_t      ar_addr_o,
    output logic [7:0]             ar_len_o,
    output logic [2:0]             ar_size_o,
    output logic [1:0]             ar_burst_o,
    output logic [2:0]             ar_prot_o,
    output logic [3:0]             ar_cache_o,
    // axi r channel
    input  logic                   r_valid_i,
    output logic                   r_ready_o,
    input  icache_pkg::word_t      r_data_i,
    input  icache_pkg::axi_resp_e  r_resp_i,
    input  logic                   r_last_i
);
    import icache_pkg::*;

    logic  lookup_en;
    addr_t lookup_addr;
    logic  hit;
    word_t array_data;

    refill_if u_refill_if ();

    icache_array u_icache_array (
        .clock         (clock),
        .reset         (reset),
        .lookup_en_i   (lookup_en),
        .lookup_addr_i (lookup_addr),
        .hit_o         (hit),
        .data_o        (array_data),
        .refill        (u_refill_if.array)
    );

    axi_refill_master u_axi_refill_master (
        .clock      (clock),
        .reset      (reset),
        .refill     (u_refill_if.master),
        .ar_valid_o (ar_valid_o),
        .ar_ready_i (ar_ready_i),
        .ar_addr_o  (ar_addr_o),
        .r_valid_i  (r_valid_i),
        .r_ready_o  (r_ready_o),
        .r_data_i   (r_data_i),
        .r_resp_i   (r_resp_i),
        .r_last_i   (r_last_i)
    );

    fetch_ctrl u_fetch_ctrl (
        .clock         (clock),
        .reset         (reset),
        .fetch_valid_i (fetch_valid_i),
        .fetch_addr_i  (fetch_addr_i),
        .fetch_ready_o (fetch_ready_o),
        .resp_valid_o  (resp_valid_o),
        .resp_data_o   (resp_data_o),
        .resp_err_o    (resp_err_o),
        .resp_ready_i  (resp_ready_i),
        .lookup_en_o   (lookup_en),
        .lookup_addr_o (lookup_addr),
        .hit_i         (hit),
        .data_i        (array_data),
        .refill        (u_refill_if.ctrl)
    );

    // every refill is the same whole-line incr burst
    assign ar_len_o   = 8'(LAST_BEAT);    // 4 beats
    assign ar_size_o  = 3'(BYTE_OFF_W);   // 8 bytes per beat
    assign ar_burst_o = AXI_BURST_INCR;
    assign ar_prot_o  = AXI_PROT_INSTR;
    assign ar_cache_o = AXI_CACHE_NORMAL_NC;

endmodule

//--- src/refill_if.sv
// refill command from the controller, beats back from the axi master
interface refill_if;
    import icache_pkg::*;

    logic      cmd_valid;
    addr_t     cmd_addr;     // line aligned
    logic      cmd_ready;

    logic      beat_valid;   // no back-pressure on beats
    beat_t     beat_idx;     // word position in the line
    word_t     beat_data;
    logic      beat_last;
    axi_resp_e beat_resp;

    modport ctrl (
        output cmd_valid, cmd_addr,
        input  cmd_ready,
        input  beat_valid, beat_idx, beat_data, beat_last, beat_resp
    );

    modport master (
        input  cmd_valid, cmd_addr,
        output cmd_ready,
        output beat_valid, beat_idx, beat_data, beat_last, beat_resp
    );

    // array only watches the command to latch the line index and tag
    modport array (
        input cmd_valid, cmd_addr, cmd_ready,
        input beat_valid, beat_idx, beat_data, beat_last, beat_resp
    );

endinterface

//--- verification/axi_mem_model.sv
// axi read slave for the cache refill port
// data is a fixed function of the beat address, bit 31 set gives slverr
module axi_mem_model (
    input  logic                   clock,
    input  logic                   reset,
    input  logic                   stall_i,      // random wait cycles from the testbench
    input  logic                   ar_valid_i,
    output logic                   ar_ready_o,
    input  icache_pkg::addr_t      ar_addr_i,
    input  logic [7:0]             ar_len_i,
    output logic                   r_valid_o,
    input  logic                   r_ready_i,
    output icache_pkg::word_t      r_data_o,
    output icache_pkg::axi_resp_e  r_resp_o,
    output logic                   r_last_o
);
    timeunit 1ns;
    timeprecision 1ps;

    import icache_pkg::*;

    logic       busy_q;         // burst accepted, beats still owed
    addr_t      addr_q;         // address of the next beat
    logic [7:0] beats_left_q;   // beats after the current one

    // upper half is the word address, lower half its inverse
    function automatic word_t word_at(input addr_t addr);
        addr_t a;
        a = {addr[31:3], 3'b000};
        return {a, ~a};
    endfunction

    always @(posedge clock or negedge reset) begin
        if (!reset) begin
            busy_q       <= 1'b0;
            addr_q       <= '0;
            beats_left_q <= '0;
            ar_ready_o   <= 1'b0;
            r_valid_o    <= 1'b0;
            r_data_o     <= '0;
            r_resp_o     <= OKAY;
            r_last_o     <= 1'b0;
        end else if (!busy_q) begin
            if (ar_valid_i && ar_ready_o) begin
                busy_q       <= 1'b1;      // ar handshake
                ar_ready_o   <= 1'b0;
                addr_q       <= ar_addr_i;
                beats_left_q <= ar_len_i;
            end else begin
                ar_ready_o <= ar_valid_i && !stall_i;
            end
        end else if (r_valid_o) begin
            if (r_ready_i) begin
                r_valid_o <= 1'b0;         // beat taken
                r_last_o  <= 1'b0;
                addr_q    <= addr_q + 32'd8;
                if (r_last_o) begin
                    busy_q <= 1'b0;
                end else begin
                    beats_left_q <= beats_left_q - 8'd1;
                end
            end
        end else if (!stall_i) begin
            r_valid_o <= 1'b1;
            r_data_o  <= word_at(addr_q);
            r_resp_o  <= addr_q[31] ? SLVERR : OKAY;   // error region above 2 GiB
            r_last_o  <= (beats_left_q == 8'd0);
        end
    end

endmodule

//--- verification/tb_icache_top.sv
module tb_icache_top;
    timeunit 1ns;
    timeprecision 1ps;

    import icache_pkg::*;

    typedef struct {
        string     name;
        addr_t     addr;
        bit        exp_hit;
        axi_resp_e exp_err;
    } fetch_test_t;

    logic      clock;
    logic      reset;
    logic      fetch_valid_i;
    addr_t     fetch_addr_i;
    logic      fetch_ready_o;
    logic      resp_valid_o;
    word_t     resp_data_o;
    axi_resp_e resp_err_o;
    logic      resp_ready_i;
    logic      ar_valid;
    logic      ar_ready;
    addr_t     ar_addr;
    logic [7:0] ar_len;
    logic [2:0] ar_size;
    logic [1:0] ar_burst;
    logic [2:0] ar_prot;
    logic [3:0] ar_cache;
    logic      r_valid;
    logic      r_ready;
    word_t     r_data;
    axi_resp_e r_resp;
    logic      r_last;
    logic      mem_stall = 1'b0;

    fetch_test_t tests[$];
    bit          table_ready = 1'b0;
    int          err_count = 0;
    int          ar_count = 0;      // ar handshakes seen on the bus
    addr_t       last_ar_addr;
    int          last_ar_len;
    int          last_ar_size;
    int          last_ar_burst;
    int          last_ar_prot;
    int          last_ar_cache;
    int unsigned stall_rng = 79182;
    int unsigned delay_rng = 79182 ^ 32'h5a5a;   // second stream, same seed

    icache_top u_icache_top (
        .clock         (clock),
        .reset         (reset),
        .fetch_valid_i (fetch_valid_i),
        .fetch_addr_i  (fetch_addr_i),
        .fetch_ready_o (fetch_ready_o),
        .resp_valid_o  (resp_valid_o),
        .resp_data_o   (resp_data_o),
        .resp_err_o    (resp_err_o),
        .resp_ready_i  (resp_ready_i),
        .ar_valid_o    (ar_valid),
        .ar_ready_i    (ar_ready),
        .ar_addr_o     (ar_addr),
        .ar_len_o      (ar_len),
        .ar_size_o     (ar_size),
        .ar_burst_o    (ar_burst),
        .ar_prot_o     (ar_prot),
        .ar_cache_o    (ar_cache),
        .r_valid_i     (r_valid),
        .r_ready_o     (r_ready),
        .r_data_i      (r_data),
        .r_resp_i      (r_resp),
        .r_last_i      (r_last)
    );

    axi_mem_model u_axi_mem_model (
        .clock      (clock),
        .reset      (reset),
        .stall_i    (mem_stall),
        .ar_valid_i (ar_valid),
        .ar_ready_o (ar_ready),
        .ar_addr_i  (ar_addr),
        .ar_len_i   (ar_len),
        .r_valid_o  (r_valid),
        .r_ready_i  (r_ready),
        .r_data_o   (r_data),
        .r_resp_o   (r_resp),
        .r_last_o   (r_last)
    );

    initial begin
        clock = 1'b0;
        forever #10 clock = ~clock;   // 50 MHz
    end

    function automatic int unsigned lcg_next(input int unsigned s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    // memory data rule, {word address, inverted word address}
    function automatic word_t expected_word(input addr_t addr);
        addr_t a;
        a = {addr[31:3], 3'b000};
        return {a, ~a};
    endfunction

    // about one cycle in four the slave stalls ar or r
    always @(posedge clock) begin
        stall_rng = lcg_next(stall_rng);
        mem_stall <= (((stall_rng >> 16) & 32'd3) == 32'd0);
    end

    // ar bus monitor
    always @(posedge clock) begin
        if (reset && ar_valid && ar_ready) begin
            ar_count++;
            last_ar_addr  = ar_addr;
            last_ar_len   = int'(ar_len);
            last_ar_size  = int'(ar_size);
            last_ar_burst = int'(ar_burst);
            last_ar_prot  = int'(ar_prot);
            last_ar_cache = int'(ar_cache);
        end
    end

    task automatic check_word(input string name, input word_t exp, input word_t act);
        if (act !== exp) begin
            $display("[FAIL] %s: expected %h, actual %h", name, exp, act);
            err_count++;
        end
    endtask

    task automatic check_resp(input string name, input axi_resp_e exp, input axi_resp_e act);
        if (act !== exp) begin
            $display("[FAIL] %s: expected %s, actual %s", name, exp.name(), act.name());
            err_count++;
        end
    endtask

    task automatic check_addr(input string name, input addr_t exp, input addr_t act);
        if (act !== exp) begin
            $display("[FAIL] %s: expected %h, actual %h", name, exp, act);
            err_count++;
        end
    endtask

    task automatic check_count(input string name, input int exp, input int act);
        if (act != exp) begin
            $display("[FAIL] %s: expected %0d, actual %0d", name, exp, act);
            err_count++;
        end
    endtask

    task automatic add_test(input string name, input addr_t addr, input bit hit,
                            input axi_resp_e err);
        fetch_test_t t;
        t.name    = name;
        t.addr    = addr;
        t.exp_hit = hit;
        t.exp_err = err;
        tests.push_back(t);
    endtask

    // index is addr[8:5], word in line is addr[4:3]
    task automatic load_table();
        add_test("first_miss",     32'h0000_1040, 1'b0, OKAY);
        add_test("repeat_hit",     32'h0000_1040, 1'b1, OKAY);
        add_test("same_line_w1",   32'h0000_1048, 1'b1, OKAY);
        add_test("same_line_w3",   32'h0000_1058, 1'b1, OKAY);
        add_test("conflict_miss",  32'h0000_2040, 1'b0, OKAY);   // index 2, new tag
        add_test("conflict_hit",   32'h0000_2050, 1'b1, OKAY);
        add_test("old_line_miss",  32'h0000_1050, 1'b0, OKAY);   // evicted above
        add_test("err_first",      32'h8000_0100, 1'b0, SLVERR);
        add_test("err_again",      32'h8000_0108, 1'b0, SLVERR); // line left invalid
        add_test("other_idx_miss", 32'h0000_03e0, 1'b0, OKAY);
        add_test("other_idx_hit",  32'h0000_03f8, 1'b1, OKAY);
        add_test("old_line_hit",   32'h0000_1040, 1'b1, OKAY);
        add_test("index0_miss",    32'h0001_0008, 1'b0, OKAY);
    endtask

    task automatic run_test(input int idx);
        string name;
        addr_t addr;
        int    ar_before;
        int    errs_before;
        int    lat;
        int    delay;
        name        = tests[idx].name;
        addr        = tests[idx].addr;
        ar_before   = ar_count;
        errs_before = err_count;
        fetch_valid_i <= 1'b1;
        fetch_addr_i  <= addr;
        @(posedge clock);
        while (!fetch_ready_o) @(posedge clock);   // request handshake on this edge
        fetch_valid_i <= 1'b0;
        lat = 0;
        do begin
            @(posedge clock);
            lat++;
        end while (!resp_valid_o);
        delay_rng = lcg_next(delay_rng);
        delay     = int'((delay_rng >> 16) % 32'd4);
        repeat (delay) begin
            @(posedge clock);
            if (!resp_valid_o || fetch_ready_o) begin
                $display("%s: response dropped or new request let in while pending", name);
                err_count++;
            end
        end
        resp_ready_i <= 1'b1;
        @(posedge clock);                          // response handshake
        resp_ready_i <= 1'b0;
        check_word({name, " data"}, expected_word(addr), resp_data_o);
        check_resp({name, " resp"}, tests[idx].exp_err, resp_err_o);
        check_count({name, " ar count"}, tests[idx].exp_hit ? 0 : 1, ar_count - ar_before);
        if (tests[idx].exp_hit) begin
            check_count({name, " hit latency"}, 2, lat);
        end else begin
            check_addr({name, " ar addr"}, addr & ~32'h1f, last_ar_addr);
            check_count({name, " ar len"}, 3, last_ar_len);
            check_count({name, " ar size"}, 3, last_ar_size);
            check_count({name, " ar burst"}, 1, last_ar_burst);   // incr
            check_count({name, " ar prot"}, 4, last_ar_prot);     // instruction access
            check_count({name, " ar cache"}, 2, last_ar_cache);   // normal non-cacheable
        end
        if (err_count == errs_before) begin
            $display("test %-15s passed", name);
        end else begin
            $display("test %-15s failed with %0d errors", name, err_count - errs_before);
        end
    endtask

    // watchdog, 200 cycles per table entry
    initial begin
        wait (table_ready);
        repeat (tests.size() * 200) @(posedge clock);
        $display("watchdog expired after %0d cycles, run did not finish", tests.size() * 200);
        $display("Done: errors found");
        $finish;
    end

    initial begin
        int n_fail;
        int n_misses;
        int errs_before;
        n_fail        = 0;
        n_misses      = 0;
        fetch_valid_i = 1'b0;
        fetch_addr_i  = '0;
        resp_ready_i  = 1'b0;
        reset         = 1'b0;
        load_table();
        table_ready = 1'b1;
        repeat (3) @(posedge clock);
        reset <= 1'b1;
        @(posedge clock);
        check_count("reset fetch_ready", 1, int'(fetch_ready_o));
        check_count("reset resp_valid", 0, int'(resp_valid_o));
        check_count("reset ar_valid", 0, int'(ar_valid));
        check_count("reset r_ready", 0, int'(r_ready));
        for (int i = 0; i < tests.size(); i++) begin
            errs_before = err_count;
            run_test(i);
            if (err_count != errs_before) n_fail++;
            if (!tests[i].exp_hit) n_misses++;
        end
        check_count("total ar handshakes", n_misses, ar_count);
        $display("summary: %0d tests, %0d passed, %0d failed, %0d errors in total",
                 tests.size(), tests.size() - n_fail, n_fail, err_count);
        if (err_count == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule
